/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_rsa_apb_top
FILELIST  = rsa_apb_top.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

/* logic/apb_pkg.sv */
`include "rsa_defs.svh"

package apb_pkg;

	// byte offsets with eight 32-bit words per operand window
	typedef enum logic [`APB_AW-1:0] {
		REG_CTRL   = 8'h00, // bit 0 starts a job
		REG_STATUS = 8'h04,
		REG_A      = 8'h10, // cipher text with word 0 as the LSW
		REG_D      = 8'h30, // private exponent
		REG_N      = 8'h50, // modulus
		REG_RES    = 8'h70  // read-only plain text
	} reg_addr_e;

	// status register bits
	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;

endpackage

/* logic/rsa_apb_regs.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_apb_regs
	import rsa_pkg::*;
	import apb_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_psel,
	input  logic               i_penable,
	input  logic               i_pwrite,
	input  logic [`APB_AW-1:0] i_paddr,
	input  logic [31:0]        i_pwdata,
	output logic [31:0]        o_prdata,
	output logic               o_pready,
	output logic               o_pslverr,
	input  logic               i_finished,
	input  rsa_word_t          i_result,
	output logic               o_start,
	output rsa_word_t          o_a,
	output rsa_word_t          o_d,
	output rsa_word_t          o_n
);
	localparam logic [`APB_AW-1:0] OP_SPAN = 'h20; // bytes per operand window

	logic [`APB_AW-1:0] word_off;
	logic [2:0]         idx;
	logic               aligned;
	logic               hit_ctrl, hit_stat, hit_a, hit_d, hit_n, hit_r;
	logic               access, bad, wr;
	logic               start_r, busy_r, done_r;
	rsa_word_t          a_r, d_r, n_r, res_r;

	// windows are 0x20 apart, so one offset gives the word index for all four
	assign word_off = i_paddr - REG_A;
	assign idx      = word_off[4:2];
	assign aligned  = (i_paddr[1:0] == 2'b00);

	assign hit_ctrl = (i_paddr == REG_CTRL);
	assign hit_stat = (i_paddr == REG_STATUS);
	assign hit_a    = aligned && (word_off < OP_SPAN);
	assign hit_d    = aligned && (i_paddr >= REG_D) && (i_paddr < REG_N);
	assign hit_n    = aligned && (i_paddr >= REG_N) && (i_paddr < REG_RES);
	assign hit_r    = aligned && (i_paddr >= REG_RES) && (i_paddr < REG_RES + OP_SPAN);

	assign access = i_psel & i_penable;
	// unmapped, or a write to a read-only register
	assign bad = !(hit_ctrl | hit_stat | hit_a | hit_d | hit_n | hit_r) |
		(i_pwrite & (hit_stat | hit_r));
	assign wr  = access & i_pwrite & !bad;

	assign o_pready  = 1'b1; // no wait states
	assign o_pslverr = access & bad;

	always_comb begin
		o_prdata = '0;
		if (hit_stat) begin
			o_prdata[STAT_BUSY] = busy_r;
			o_prdata[STAT_DONE] = done_r;
		end else if (hit_a) begin
			o_prdata = a_r[idx*32 +: 32];
		end else if (hit_d) begin
			o_prdata = d_r[idx*32 +: 32];
		end else if (hit_n) begin
			o_prdata = n_r[idx*32 +: 32];
		end else if (hit_r) begin
			o_prdata = res_r[idx*32 +: 32];
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			start_r <= 1'b0;
			busy_r  <= 1'b0;
			done_r  <= 1'b0;
		end else begin
			start_r <= 1'b0;
			if (wr && hit_ctrl && i_pwdata[0] && !busy_r) begin
				start_r <= 1'b1;
				busy_r  <= 1'b1;
				done_r  <= 1'b0; // stale result no longer valid
			end else if (i_finished) begin
				busy_r <= 1'b0;
				done_r <= 1'b1;
			end
		end
	end

	// operands frozen while a job runs
	always_ff @(posedge i_clk) begin
		if (wr && !busy_r) begin
			if (hit_a) a_r[idx*32 +: 32] <= i_pwdata;
			if (hit_d) d_r[idx*32 +: 32] <= i_pwdata;
			if (hit_n) n_r[idx*32 +: 32] <= i_pwdata;
		end
		if (i_finished) res_r <= i_result;
	end

	assign o_start = start_r;
	assign o_a     = a_r;
	assign o_d     = d_r;
	assign o_n     = n_r;

endmodule

/* logic/rsa_apb_top.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_apb_top
	import rsa_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_psel,
	input  logic               i_penable,
	input  logic               i_pwrite,
	input  logic [`APB_AW-1:0] i_paddr,
	input  logic [31:0]        i_pwdata,
	output logic [31:0]        o_prdata,
	output logic               o_pready,
	output logic               o_pslverr
);
	logic      start, finished;
	rsa_word_t op_a, op_d, op_n, result;

	rsa_apb_regs u_regs (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_psel     (i_psel),
		.i_penable  (i_penable),
		.i_pwrite   (i_pwrite),
		.i_paddr    (i_paddr),
		.i_pwdata   (i_pwdata),
		.o_prdata   (o_prdata),
		.o_pready   (o_pready),
		.o_pslverr  (o_pslverr),
		.i_finished (finished),
		.i_result   (result),
		.o_start    (start),
		.o_a        (op_a),
		.o_d        (op_d),
		.o_n        (op_n)
	);

	rsa_core u_core (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (start),
		.i_a        (op_a),
		.i_d        (op_d),
		.i_n        (op_n),
		.o_a_pow_d  (result),
		.o_finished (finished)
	);

endmodule

/* logic/rsa_core.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_core
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_a, // cipher text
	input  rsa_word_t i_d, // private exponent
	input  rsa_word_t i_n, // modulus, odd
	output rsa_word_t o_a_pow_d,
	output logic      o_finished
);
	core_state_e           state_r;
	logic [`RSA_CNT_W-1:0] cnt_r; // exponent bit index
	logic                  prep_rst_r, prep_start_r, prep_ready;
	logic                  mul_rst_r, mul_start_r;
	logic                  mul_m_ready, mul_t_ready, mont_done_r;
	logic                  finished_r;
	rsa_word_t             prep_t, mul_m_out, mul_t_out;
	rsa_word_t             m_r, t_r, m_new_r, t_new_r;

	rsa_mod_prep u_prep (
		.i_clk   (i_clk),
		.i_rst   (prep_rst_r),
		.i_start (prep_start_r),
		.i_n     (i_n),
		.i_b     (i_a),
		.o_t     (prep_t),
		.o_ready (prep_ready)
	);

	// running product m * t
	rsa_mont_mul u_mul_m (
		.i_clk   (i_clk),
		.i_rst   (mul_rst_r),
		.i_start (mul_start_r),
		.i_n     (i_n),
		.i_a     (m_r),
		.i_b     (t_r),
		.o_m     (mul_m_out),
		.o_ready (mul_m_ready)
	);

	// running square t * t
	rsa_mont_mul u_mul_t (
		.i_clk   (i_clk),
		.i_rst   (mul_rst_r),
		.i_start (mul_start_r),
		.i_n     (i_n),
		.i_a     (t_r),
		.i_b     (t_r),
		.o_m     (mul_t_out),
		.o_ready (mul_t_ready)
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r      <= S_IDLE;
			cnt_r        <= '0;
			prep_rst_r   <= 1'b1; // submodules held in reset while unused
			prep_start_r <= 1'b0;
			mul_rst_r    <= 1'b1;
			mul_start_r  <= 1'b0;
			mont_done_r  <= 1'b0;
			finished_r   <= 1'b0;
		end else begin
			prep_start_r <= 1'b0;
			mul_start_r  <= 1'b0;
			finished_r   <= 1'b0;
			mont_done_r  <= mul_m_ready & mul_t_ready;
			case (state_r)
				S_IDLE: if (i_start) begin
					state_r      <= S_PREP;
					prep_rst_r   <= 1'b0;
					prep_start_r <= 1'b1;
				end
				S_PREP: if (prep_ready) begin
					state_r     <= S_MONT;
					prep_rst_r  <= 1'b1;
					mul_rst_r   <= 1'b0;
					mul_start_r <= 1'b1;
					cnt_r       <= '0;
				end
				S_MONT: if (mont_done_r) begin
					state_r   <= S_CALC;
					mul_rst_r <= 1'b1; // drops both ready flags
				end
				S_CALC: begin
					if (cnt_r == `RSA_CNT_W'(`RSA_WIDTH - 1)) begin
						state_r    <= S_IDLE;
						finished_r <= 1'b1;
					end else begin
						state_r     <= S_MONT;
						mul_rst_r   <= 1'b0;
						mul_start_r <= 1'b1;
						cnt_r       <= cnt_r + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (mul_m_ready && mul_t_ready) begin
			m_new_r <= mul_m_out;
			t_new_r <= mul_t_out;
		end
		if (state_r == S_PREP && prep_ready) begin
			t_r <= prep_t;
			m_r <= rsa_word_t'(1); // m stays in the plain domain
		end else if (state_r == S_CALC) begin
			t_r <= t_new_r;
			if (i_d[cnt_r[`RSA_CNT_W-2:0]]) m_r <= m_new_r;
		end
	end

	assign o_a_pow_d  = m_r; // final after the last calc step
	assign o_finished = finished_r;

endmodule

/* logic/rsa_defs.svh */
`ifndef RSA_DEFS_SVH
`define RSA_DEFS_SVH

// operand width in bits
`define RSA_WIDTH 256

// round and iteration counters need one bit more than an operand bit index
`define RSA_CNT_W 9

// byte address on the APB side
`define APB_AW 8

`endif

/* logic/rsa_mod_prep.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_mod_prep
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_n,
	input  rsa_word_t i_b,
	output rsa_word_t o_t,
	output logic      o_ready
);
	logic                  busy_r, ready_r;
	logic [`RSA_CNT_W-1:0] cnt_r;
	rsa_wide_t             t_r, dbl, n_wide;

	assign n_wide = {2'b00, i_n};
	assign dbl    = t_r << 1; // t < n, so 2t still fits

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy_r  <= 1'b0;
			ready_r <= 1'b0;
			cnt_r   <= '0;
		end else if (i_start) begin
			busy_r  <= 1'b1;
			ready_r <= 1'b0;
			cnt_r   <= '0;
		end else if (busy_r) begin
			if (cnt_r == `RSA_CNT_W'(`RSA_WIDTH)) begin
				busy_r  <= 1'b0;
				ready_r <= 1'b1; // held until local reset
			end else begin
				cnt_r <= cnt_r + 1'b1;
			end
		end
	end

	// one doubling per cycle and a single subtraction keeps it below n
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			t_r <= {2'b00, i_b};
		end else if (busy_r && cnt_r != `RSA_CNT_W'(`RSA_WIDTH)) begin
			t_r <= (dbl >= n_wide) ? dbl - n_wide : dbl;
		end
	end

	assign o_t     = t_r[`RSA_WIDTH-1:0];
	assign o_ready = ready_r;

endmodule

/* logic/rsa_mont_mul.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_mont_mul
	import rsa_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_start,
	input  rsa_word_t i_n,
	input  rsa_word_t i_a,
	input  rsa_word_t i_b,
	output rsa_word_t o_m,
	output logic      o_ready
);
	logic                  busy_r, ready_r;
	logic [`RSA_CNT_W-1:0] cnt_r;
	rsa_wide_t             s_r, acc, acc_n, n_wide, b_wide;
	logic                  iter, fixup;

	assign n_wide = {2'b00, i_n};
	assign b_wide = {2'b00, i_b};

	// 256 halving steps, then one cycle for the final subtraction
	assign iter  = busy_r && (cnt_r < `RSA_CNT_W'(`RSA_WIDTH));
	assign fixup = busy_r && (cnt_r == `RSA_CNT_W'(`RSA_WIDTH));

	// s stays below 2n, so s + b + n fits in the guard bits
	assign acc   = s_r + (i_a[cnt_r[`RSA_CNT_W-2:0]] ? b_wide : '0);
	assign acc_n = acc[0] ? acc + n_wide : acc; // make it even

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy_r  <= 1'b0;
			ready_r <= 1'b0;
			cnt_r   <= '0;
		end else if (i_start) begin
			busy_r  <= 1'b1;
			ready_r <= 1'b0;
			cnt_r   <= '0;
		end else if (busy_r) begin
			if (cnt_r == `RSA_CNT_W'(`RSA_WIDTH + 1)) begin
				busy_r  <= 1'b0;
				ready_r <= 1'b1;
			end else begin
				cnt_r <= cnt_r + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) s_r <= '0;
		else if (iter) s_r <= acc_n >> 1;
		else if (fixup && s_r >= n_wide) s_r <= s_r - n_wide;
	end

	assign o_m     = s_r[`RSA_WIDTH-1:0];
	assign o_ready = ready_r;

endmodule

/* logic/rsa_pkg.sv */
`include "rsa_defs.svh"

package rsa_pkg;

	// one full operand
	typedef logic [`RSA_WIDTH-1:0] rsa_word_t;

	// two guard bits for the 2n and 4n intermediates
	typedef logic [`RSA_WIDTH+1:0] rsa_wide_t;

	typedef enum logic [1:0] {
		S_IDLE, // waiting for start
		S_PREP, // cipher text into Montgomery domain
		S_MONT, // both multipliers running
		S_CALC  // pick up square and product, next bit
	} core_state_e;

endpackage

/* rsa_apb_top.f */
+incdir+logic
logic/rsa_pkg.sv
logic/apb_pkg.sv
logic/rsa_apb_regs.sv
logic/rsa_mod_prep.sv
logic/rsa_mont_mul.sv
logic/rsa_core.sv
logic/rsa_apb_top.sv
verif/tb_rsa_apb_top.sv

/* verif/tb_rsa_apb_top.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module tb_rsa_apb_top
	import rsa_pkg::*;
	import apb_pkg::*;
();
	localparam int POLL_LIMIT   = 100000; // status reads per job
	localparam int PREADY_LIMIT = 16;

	logic               clk, rst;
	logic               psel, penable, pwrite;
	logic [`APB_AW-1:0] paddr;
	logic [31:0]        pwdata, prdata;
	logic               pready, pslverr;
	int                 errors, checks;
	integer             seed;

	rsa_apb_top u_rsa_apb_top (
		.i_clk     (clk),
		.i_rst     (rst),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic end_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input rsa_word_t got, input rsa_word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	// a^d mod n by plain square-and-multiply on double-width values
	function automatic rsa_word_t mod_exp(input rsa_word_t base, input rsa_word_t e,
			input rsa_word_t modulus);
		logic [511:0] r, b, n;
		n = 512'(modulus);
		r = 512'd1;
		b = 512'(base) % n;
		for (int i = 0; i < `RSA_WIDTH; i++) begin
			if (e[i]) r = (r * b) % n;
			b = (b * b) % n;
		end
		return r[`RSA_WIDTH-1:0];
	endfunction

	function automatic logic [`APB_AW-1:0] word_addr(input logic [`APB_AW-1:0] base, input int i);
		return base + `APB_AW'(i * 4);
	endfunction

	// one setup and one access phase with inputs moved 1 ns after the edge
	task automatic apb_access(input logic write, input logic [`APB_AW-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#2; // sample just ahead of the closing edge
		check_bit("o_pready", pready, 1'b1); // no wait states expected
		waits = 0;
		while (!pready && waits < PREADY_LIMIT) begin
			@(posedge clk);
			#3;
			waits++;
		end
		if (!pready) begin
			errors++;
			$display("APB slave never raised pready at address %0h", addr);
			end_run();
		end else begin
			rdata = prdata;
			err   = pslverr;
			@(posedge clk);
			#1;
			psel    = 1'b0;
			penable = 1'b0;
			pwrite  = 1'b0;
		end
	endtask

	task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic        err;
		apb_access(1'b1, addr, data, unused, err);
		check_bit("o_pslverr", err, 1'b0);
	endtask

	task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [31:0] data);
		logic err;
		apb_access(1'b0, addr, 32'h0, data, err);
		check_bit("o_pslverr", err, 1'b0);
	endtask

	task automatic expect_error(input logic write, input logic [`APB_AW-1:0] addr,
			input logic [31:0] data);
		logic [31:0] unused;
		logic        err;
		apb_access(write, addr, data, unused, err);
		check_bit("o_pslverr", err, 1'b1);
	endtask

	task automatic load_operands(input rsa_word_t a, input rsa_word_t d, input rsa_word_t n);
		for (int i = 0; i < 8; i++) begin
			apb_write(word_addr(REG_A, i), a[i*32 +: 32]);
			apb_write(word_addr(REG_D, i), d[i*32 +: 32]);
			apb_write(word_addr(REG_N, i), n[i*32 +: 32]);
		end
	endtask

	task automatic read_result(output rsa_word_t res);
		logic [31:0] w;
		for (int i = 0; i < 8; i++) begin
			apb_read(word_addr(REG_RES, i), w);
			res[i*32 +: 32] = w;
		end
	endtask

	task automatic wait_done();
		logic [31:0] st;
		int          polls;
		st    = 32'h1;
		polls = 0;
		while (st[STAT_BUSY] && polls < POLL_LIMIT) begin
			apb_read(REG_STATUS, st);
			polls++;
		end
		if (st[STAT_BUSY]) begin
			errors++;
			$display("engine still busy after %0d status reads", polls);
			end_run();
		end else begin
			check_word("status", st, 32'h2); // done and not busy
		end
	endtask

	// odd modulus with the top bit set and cipher text below it
	task automatic make_operands(output rsa_word_t a, output rsa_word_t d, output rsa_word_t n);
		for (int i = 0; i < 8; i++) begin
			a[i*32 +: 32] = $random(seed);
			d[i*32 +: 32] = $random(seed);
			n[i*32 +: 32] = $random(seed);
		end
		n[0]              = 1'b1;
		n[`RSA_WIDTH-1]   = 1'b1;
		a                 = a % n;
	endtask

	task automatic run_job(input rsa_word_t a, input rsa_word_t d, input rsa_word_t n,
			output rsa_word_t res);
		load_operands(a, d, n);
		apb_write(REG_CTRL, 32'h1);
		wait_done();
		read_result(res);
	endtask

	task automatic test_reset_and_regs();
		logic [31:0] st, w;
		logic [31:0] wa [8];
		logic [31:0] wd [8];
		logic [31:0] wn [8];
		check_bit("o_pslverr", pslverr, 1'b0);
		apb_read(REG_STATUS, st);
		check_word("status", st, 32'h0);
		for (int i = 0; i < 8; i++) begin
			wa[i] = $random(seed);
			wd[i] = $random(seed);
			wn[i] = $random(seed);
			apb_write(word_addr(REG_A, i), wa[i]);
			apb_write(word_addr(REG_D, i), wd[i]);
			apb_write(word_addr(REG_N, i), wn[i]);
		end
		for (int i = 0; i < 8; i++) begin
			apb_read(word_addr(REG_A, i), w);
			check_word("a word", w, wa[i]);
			apb_read(word_addr(REG_D, i), w);
			check_word("d word", w, wd[i]);
			apb_read(word_addr(REG_N, i), w);
			check_word("n word", w, wn[i]);
		end
	endtask

	task automatic test_known_case();
		rsa_word_t   res;
		logic [31:0] st;
		run_job(256'd2790, 256'd2753, 256'd3233, res);
		check_op("result", res, 256'd65);
		read_result(res); // second read must not disturb anything
		check_op("result", res, 256'd65);
		apb_read(REG_STATUS, st);
		check_word("status", st, 32'h2);
	endtask

	task automatic test_random_cases();
		rsa_word_t a, d, n, res;
		for (int k = 0; k < 3; k++) begin
			make_operands(a, d, n);
			run_job(a, d, n, res);
			check_op("result", res, mod_exp(a, d, n));
		end
	endtask

	task automatic test_busy_lockout();
		rsa_word_t   a, d, n, res;
		logic [31:0] st, w;
		make_operands(a, d, n);
		load_operands(a, d, n);
		apb_write(REG_CTRL, 32'h1);
		apb_read(REG_STATUS, st);
		check_word("status", st, 32'h1); // busy with the old done cleared
		apb_write(REG_CTRL, 32'h1);      // dropped
		apb_write(word_addr(REG_N, 0), ~n[31:0]);
		apb_read(word_addr(REG_N, 0), w);
		check_word("n word", w, n[31:0]);
		wait_done();
		read_result(res);
		check_op("result", res, mod_exp(a, d, n));
		apb_read(REG_STATUS, st);
		check_word("status", st, 32'h2); // no queued second job
	endtask

	task automatic test_bus_errors();
		logic [31:0] a0, r0, st, w;
		apb_read(word_addr(REG_A, 0), a0);
		apb_read(REG_RES, r0);
		expect_error(1'b0, 8'h90, 32'h0);
		expect_error(1'b1, 8'h90, 32'hdead_beef);
		expect_error(1'b1, 8'hfc, 32'hdead_beef);
		expect_error(1'b1, 8'h12, 32'hdead_beef); // misaligned inside the a window
		expect_error(1'b1, REG_STATUS, 32'h0);
		expect_error(1'b1, REG_RES, 32'hffff_ffff);
		apb_read(REG_STATUS, st);
		check_word("status", st, 32'h2);
		apb_read(word_addr(REG_A, 0), w);
		check_word("a word", w, a0);
		apb_read(REG_RES, w);
		check_word("result word", w, r0);
	endtask

	initial begin
		seed    = 32'hff75;
		errors  = 0;
		checks  = 0;
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		test_reset_and_regs();
		test_known_case();
		test_random_cases();
		test_busy_lockout();
		test_bus_errors();
		end_run();
	end

endmodule
